//--- Makefile
TOP := tb_multicore_bus

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f project.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- common/bus_pkg.sv
package bus_pkg;

    // widths shared by the front-side ports and the AXI4-Lite side.
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W = DATA_W / 8;

    // one front-side request, as a hart presents it on its instruction
    // or data port. The controller forwards the granted one to the bridge
    // in the same form.
    typedef struct packed {
        logic dren;
        logic dwen;
        logic [ADDR_W-1:0] daddr;
        logic [DATA_W-1:0] dstore;
        logic [BE_W-1:0] dbyte_en;
    } fsb_req_t;

    // response back to one front-side port.
    // dwait drops for a single cycle when the transfer completes.
    typedef struct packed {
        logic dwait;
        logic [DATA_W-1:0] dload;
        logic derror;
    } fsb_rsp_t;

    // answer from the bridge to the controller.
    // rdata and error are valid in the first cycle busy is low again.
    typedef struct packed {
        logic busy;
        logic [DATA_W-1:0] rdata;
        logic error;
    } gen_rsp_t;

    // AXI4-Lite response codes used on the B and R channels.
    typedef enum logic [1:0] {
        OKAY = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    // exclusive access is not part of AXI4-Lite, and a decode error is
    // reported by the interconnect. Anything other than OKAY is treated
    // as a failed transfer by the bridge.

endpackage

//--- memory_controller/bus_timeout_timer.sv
module bus_timeout_timer #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input logic CLK,
    input logic rst_n,
    input logic clear,
    input logic run,
    output logic expired
);
    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    // cycles spent waiting on the AXI side for the current transfer.
    logic [CNT_W-1:0] count;

    // the count saturates, so expired holds until the next clear.
    assign expired = (count == CNT_W'(TIMEOUT_CYCLES));

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (run && !expired) begin
            count <= count + 1'b1;
        end
    end

    // clear wins over run.
    // a new transfer always starts from zero even if the previous one
    // was still being counted when it was abandoned.

    // with TIMEOUT_CYCLES of 64 the counter is seven bits wide and stops
    // at 64, well short of wrapping.
endmodule

//--- memory_controller/memory_controller.sv
module memory_controller #(
    parameter int NUM_HARTS = 2,
    parameter int TIMEOUT_CYCLES = 64
) (
    input logic CLK,
    input logic rst_n,
    input bus_pkg::fsb_req_t [2*NUM_HARTS-1:0] fsb_req,
    output bus_pkg::fsb_rsp_t [2*NUM_HARTS-1:0] fsb_rsp,
    output bus_pkg::fsb_req_t gen_req,
    output logic start,
    input bus_pkg::gen_rsp_t gen_rsp
);
    import bus_pkg::*;

    localparam int NUM_REQ = 2 * NUM_HARTS;
    localparam int IDX_W = $clog2(NUM_REQ);

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        WAIT,
        RESPOND,
        DRAIN
    } state_t;

    state_t state;
    logic [IDX_W-1:0] grant_q;
    logic timed_out_q;
    logic [DATA_W-1:0] rsp_data_q;
    logic rsp_err_q;

    logic [NUM_REQ-1:0] pending;
    logic [IDX_W-1:0] grant_idx;
    logic grant_valid;
    logic advance;
    logic expired;
    logic xfer_done;

    // once a requester is granted, only its own bit is shown to the
    // arbiter, so grant_idx still names it when the pointer advances.
    always_comb begin
        for (int i = 0; i < NUM_REQ; i++) begin
            pending[i] = (fsb_req[i].dren || fsb_req[i].dwen)
                         && (state == IDLE || grant_q == IDX_W'(i));
        end
    end

    request_arbiter #(
        .NUM_HARTS(NUM_HARTS)
    ) u_request_arbiter (
        .CLK(CLK),
        .rst_n(rst_n),
        .pending(pending),
        .advance(advance),
        .grant_idx(grant_idx),
        .grant_valid(grant_valid)
    );

    bus_timeout_timer #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) u_bus_timeout_timer (
        .CLK(CLK),
        .rst_n(rst_n),
        .clear(start),
        .run(state == WAIT),
        .expired(expired)
    );

    assign start = (state == ISSUE);
    assign gen_req = fsb_req[grant_q];
    assign xfer_done = !gen_rsp.busy;
    assign advance = (state == WAIT) && (xfer_done || expired);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state <= IDLE;
            grant_q <= '0;
            timed_out_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (grant_valid) begin
                        grant_q <= grant_idx;
                        state <= ISSUE;
                    end
                end
                ISSUE: state <= WAIT;
                WAIT: begin
                    if (xfer_done) begin
                        timed_out_q <= 1'b0;
                        state <= RESPOND;
                    end else if (expired) begin
                        timed_out_q <= 1'b1;
                        state <= RESPOND;
                    end
                end
                // a timed out transfer still owes an AXI response.
                RESPOND: state <= timed_out_q ? DRAIN : IDLE;
                DRAIN: begin
                    if (xfer_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == WAIT) begin
            rsp_data_q <= xfer_done ? gen_rsp.rdata : '0;
            rsp_err_q <= xfer_done ? gen_rsp.error : 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_REQ; i++) begin
            fsb_rsp[i].dwait = !(state == RESPOND && grant_q == IDX_W'(i));
            fsb_rsp[i].dload = rsp_data_q;
            fsb_rsp[i].derror = !fsb_rsp[i].dwait && rsp_err_q;
        end
    end
endmodule

//--- memory_controller/request_arbiter.sv
module request_arbiter #(
    parameter int NUM_HARTS = 2
) (
    input logic CLK,
    input logic rst_n,
    input logic [2*NUM_HARTS-1:0] pending,
    input logic advance,
    output logic [$clog2(2*NUM_HARTS)-1:0] grant_idx,
    output logic grant_valid
);
    localparam int NUM_REQ = 2 * NUM_HARTS;
    localparam int IDX_W = $clog2(NUM_REQ);

    // the requester with the highest priority this round.
    logic [IDX_W-1:0] ptr;

    // walk the offsets from the far end back towards the pointer, so the
    // last hit written is the first set bit at or after the pointer.
    always_comb begin
        int unsigned cand;
        grant_idx = '0;
        grant_valid = 1'b0;
        for (int off = NUM_REQ - 1; off >= 0; off--) begin
            cand = int'(ptr) + off;
            if (cand >= NUM_REQ) begin
                cand = cand - NUM_REQ;
            end
            if (pending[cand]) begin
                grant_idx = IDX_W'(cand);
                grant_valid = 1'b1;
            end
        end
    end

    // the served requester drops to lowest priority.
    // Its neighbour becomes the first to be looked at.
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (advance) begin
            if (grant_idx == IDX_W'(NUM_REQ - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= grant_idx + 1'b1;
            end
        end
    end

    // NUM_REQ is even and at least two, so IDX_W is never zero and every
    // value of ptr below NUM_REQ is reachable.
    // a non power of two requester count simply wraps early.
endmodule

//--- project.f
common/bus_pkg.sv
memory_controller/request_arbiter.sv
memory_controller/bus_timeout_timer.sv
memory_controller/memory_controller.sv
source/axi_lite_bridge.sv
source/multicore_bus_wrapper.sv
test/tb_clock_gen.sv
test/tb_multicore_bus.sv

//--- source/axi_lite_bridge.sv
module axi_lite_bridge (
    input logic CLK,
    input logic rst_n,
    input bus_pkg::fsb_req_t gen_req,
    input logic start,
    output bus_pkg::gen_rsp_t gen_rsp,
    output logic [bus_pkg::ADDR_W-1:0] awaddr,
    output logic awvalid,
    input logic awready,
    output logic [bus_pkg::DATA_W-1:0] wdata,
    output logic [bus_pkg::BE_W-1:0] wstrb,
    output logic wvalid,
    input logic wready,
    input logic [1:0] bresp,
    input logic bvalid,
    output logic bready,
    output logic [bus_pkg::ADDR_W-1:0] araddr,
    output logic arvalid,
    input logic arready,
    input logic [bus_pkg::DATA_W-1:0] rdata,
    input logic [1:0] rresp,
    input logic rvalid,
    output logic rready
);
    import bus_pkg::*;

    fsb_req_t req_q;
    logic busy_q;
    logic [DATA_W-1:0] rdata_q;
    logic error_q;

    // valids still waiting for their handshake after this cycle.
    logic aw_left;
    logic w_left;

    assign aw_left = awvalid && !awready;
    assign w_left = wvalid && !wready;

    assign awaddr = req_q.daddr;
    assign wdata = req_q.dstore;
    assign wstrb = req_q.dbyte_en;
    assign araddr = req_q.daddr;

    assign gen_rsp = '{busy: busy_q, rdata: rdata_q, error: error_q};

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            bready <= 1'b0;
            arvalid <= 1'b0;
            rready <= 1'b0;
        end else if (start) begin
            busy_q <= 1'b1;
            awvalid <= gen_req.dwen;
            wvalid <= gen_req.dwen;
            arvalid <= !gen_req.dwen;
        end else if (busy_q) begin
            awvalid <= aw_left;
            wvalid <= w_left;
            // write response is accepted only once address and data are in.
            if (req_q.dwen && !bready && !aw_left && !w_left) begin
                bready <= 1'b1;
            end
            if (bvalid && bready) begin
                bready <= 1'b0;
                busy_q <= 1'b0;
            end
            if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready <= 1'b1;
            end
            if (rvalid && rready) begin
                rready <= 1'b0;
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            req_q <= gen_req;
        end
        if (busy_q && bvalid && bready) begin
            rdata_q <= '0;
            error_q <= (bresp != OKAY);
        end
        if (busy_q && rvalid && rready) begin
            rdata_q <= rdata;
            error_q <= (rresp != OKAY);
        end
    end
endmodule

//--- source/multicore_bus_wrapper.sv
module multicore_bus_wrapper #(
    parameter int NUM_HARTS = 2,
    parameter int TIMEOUT_CYCLES = 64
) (
    input logic CLK,
    input logic rst_n,
    input bus_pkg::fsb_req_t [2*NUM_HARTS-1:0] fsb_req,
    output bus_pkg::fsb_rsp_t [2*NUM_HARTS-1:0] fsb_rsp,
    output logic [bus_pkg::ADDR_W-1:0] awaddr,
    output logic awvalid,
    input logic awready,
    output logic [bus_pkg::DATA_W-1:0] wdata,
    output logic [bus_pkg::BE_W-1:0] wstrb,
    output logic wvalid,
    input logic wready,
    input logic [1:0] bresp,
    input logic bvalid,
    output logic bready,
    output logic [bus_pkg::ADDR_W-1:0] araddr,
    output logic arvalid,
    input logic arready,
    input logic [bus_pkg::DATA_W-1:0] rdata,
    input logic [1:0] rresp,
    input logic rvalid,
    output logic rready
);
    import bus_pkg::*;

    // requester ports are ordered instruction, data for each hart.
    fsb_req_t gen_req;
    gen_rsp_t gen_rsp;
    logic start;

    memory_controller #(
        .NUM_HARTS(NUM_HARTS),
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) u_memory_controller (
        .CLK(CLK),
        .rst_n(rst_n),
        .fsb_req(fsb_req),
        .fsb_rsp(fsb_rsp),
        .gen_req(gen_req),
        .start(start),
        .gen_rsp(gen_rsp)
    );

    axi_lite_bridge u_axi_lite_bridge (
        .CLK(CLK),
        .rst_n(rst_n),
        .gen_req(gen_req),
        .start(start),
        .gen_rsp(gen_rsp),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready)
    );
endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen (
    output logic CLK,
    output logic rst_n
);
    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // reset is held low over the first three rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge CLK);
        #1;
        rst_n = 1'b1;
    end
endmodule

//--- test/tb_multicore_bus.sv
module tb_multicore_bus;
    import bus_pkg::*;

    localparam int NUM_HARTS = 2;
    localparam int TIMEOUT_CYCLES = 64;
    localparam int NUM_REQ = 2 * NUM_HARTS;
    localparam int NUM_RANDOM = 40;

    // port r of a step uses addr + 4*r and data + r.
    typedef struct packed {
        logic [NUM_REQ-1:0] mask;
        logic wr;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [BE_W-1:0] be;
        logic [NUM_REQ-1:0][DATA_W-1:0] exp;
        logic err;
    } step_t;

    logic CLK;
    logic rst_n;
    fsb_req_t [NUM_REQ-1:0] fsb_req;
    fsb_rsp_t [NUM_REQ-1:0] fsb_rsp;
    logic [ADDR_W-1:0] awaddr, araddr;
    logic [DATA_W-1:0] wdata, rdata;
    logic [BE_W-1:0] wstrb;
    logic [1:0] bresp, rresp;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;

    logic [DATA_W-1:0] mem [256];
    logic [DATA_W-1:0] ref_mem [256];
    step_t steps [$];
    string step_names [$];
    int grant_ptr;

    tb_clock_gen u_clock_gen (
        .CLK(CLK),
        .rst_n(rst_n)
    );

    multicore_bus_wrapper #(
        .NUM_HARTS(NUM_HARTS),
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) u_dut (.*);

    function automatic logic [DATA_W-1:0] fill_word(input int idx);
        return 32'hC0DE_0000 + 32'(idx) * 32'h0001_0101;
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] result;
        result = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic is_slverr_page(input logic [ADDR_W-1:0] a);
        return a[31:28] == 4'hE;
    endfunction

    function automatic logic is_stall_page(input logic [ADDR_W-1:0] a);
        return a[31:28] == 4'hF;
    endfunction

    // first waiting port at or after the pointer, wrapping around.
    function automatic int next_grant(input int from, input logic [NUM_REQ-1:0] waiting);
        int idx;
        for (int off = 0; off < NUM_REQ; off++) begin
            idx = (from + off) % NUM_REQ;
            if (waiting[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge CLK);
            #1;
        end
    endtask

    // expected loads come from the reference memory as it stands when the step runs.
    task automatic add_step(input string name, input logic [NUM_REQ-1:0] mask, input logic wr,
                            input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [BE_W-1:0] be);
        step_t st;
        logic [ADDR_W-1:0] a;
        st = '0;
        st.mask = mask;
        st.wr = wr;
        st.addr = addr;
        st.data = data;
        st.be = be;
        st.err = is_slverr_page(addr) || is_stall_page(addr);
        for (int r = 0; r < NUM_REQ; r++) begin
            a = addr + ADDR_W'(4 * r);
            if (mask[r] && wr && !st.err) begin
                ref_mem[a[9:2]] = merge_bytes(ref_mem[a[9:2]], data + DATA_W'(r), be);
            end
            if (mask[r] && !wr && !st.err) begin
                st.exp[r] = ref_mem[a[9:2]];
            end
        end
        steps.push_back(st);
        step_names.push_back(name);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        for (int r = 0; r < NUM_REQ; r++) begin
            add_step($sformatf("write_port%0d", r), NUM_REQ'(1) << r, 1'b1, 32'h0000_0200,
                     32'hA0B1_C2D0, 4'(4'b0101 << (r % 2)));
            add_step($sformatf("read_port%0d", r), NUM_REQ'(1) << r, 1'b0, 32'h0000_0200,
                     '0, '0);
        end
        add_step("write_all_low", 4'b1111, 1'b1, 32'h0000_0100, 32'h1122_3340, 4'b0011);
        // a lone grant to port 1 leaves the round-robin pointer at port 2.
        add_step("read_port1_low", 4'b0010, 1'b0, 32'h0000_0100, '0, '0);
        add_step("read_all_low", 4'b1111, 1'b0, 32'h0000_0100, '0, '0);
        add_step("write_all_full", 4'b1111, 1'b1, 32'h0000_0300, 32'hCAFE_0000, 4'b1111);
        add_step("read_all_full", 4'b1011, 1'b0, 32'h0000_0300, '0, '0);
        add_step("slverr_write", 4'b0010, 1'b1, 32'hE000_0040, 32'h5555_5555, 4'b1111);
        add_step("slverr_read", 4'b0100, 1'b0, 32'hE000_0080, '0, '0);
        add_step("read_after_slverr", 4'b0001, 1'b0, 32'h0000_0100, '0, '0);
        add_step("stall_read", 4'b0001, 1'b0, 32'hF000_0000, '0, '0);
        add_step("read_after_stall", 4'b0010, 1'b0, 32'h0000_0104, '0, '0);
        add_step("stall_write", 4'b1000, 1'b1, 32'hF000_0100, 32'h7777_7777, 4'b1111);
        add_step("read_after_stall_write", 4'b0100, 1'b0, 32'h0000_0308, '0, '0);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $urandom;
            add_step($sformatf("random_%0d", i), NUM_REQ'(1) << rnd[1:0], rnd[2],
                     {24'd0, rnd[13:8], 2'b00}, $urandom, rnd[7:4]);
        end
    endtask

    task automatic check_reset_state();
        for (int r = 0; r < NUM_REQ; r++) begin
            check_value($sformatf("reset port%0d dwait", r), 32'd1, 32'(fsb_rsp[r].dwait));
            check_value($sformatf("reset port%0d derror", r), 32'd0, 32'(fsb_rsp[r].derror));
        end
        check_value("reset awvalid", 32'd0, 32'(awvalid));
        check_value("reset arvalid", 32'd0, 32'(arvalid));
    endtask

    task automatic apply_step(input int s);
        step_t st;
        logic [NUM_REQ-1:0] waiting;
        string name;
        st = steps[s];
        waiting = st.mask;
        for (int r = 0; r < NUM_REQ; r++) begin
            if (st.mask[r]) begin
                fsb_req[r].dren = !st.wr;
                fsb_req[r].dwen = st.wr;
                fsb_req[r].daddr = st.addr + ADDR_W'(4 * r);
                fsb_req[r].dstore = st.data + DATA_W'(r);
                fsb_req[r].dbyte_en = st.be;
            end
        end
        while (waiting != '0) begin
            @(posedge CLK);
            #1;
            for (int r = 0; r < NUM_REQ; r++) begin
                name = $sformatf("%s port%0d", step_names[s], r);
                if (!fsb_rsp[r].dwait && !waiting[r]) begin
                    fail_run($sformatf("%s completed a transfer it never requested", name));
                end else if (!fsb_rsp[r].dwait) begin
                    check_value({name, " order"}, DATA_W'(next_grant(grant_ptr, waiting)),
                                DATA_W'(r));
                    check_value({name, " derror"}, DATA_W'(st.err), 32'(fsb_rsp[r].derror));
                    if (!st.wr) begin
                        check_value({name, " dload"}, st.exp[r], fsb_rsp[r].dload);
                    end
                    waiting[r] = 1'b0;
                    grant_ptr = (r + 1) % NUM_REQ;
                    fsb_req[r] = '0;
                end
            end
        end
    endtask

    // AXI4-Lite subordinate. The stall page answers long after the bus timeout.
    task automatic serve_write();
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        logic [BE_W-1:0] s;
        idle_cycles($urandom_range(0, 3));
        awready = 1'b1;
        a = awaddr;
        idle_cycles(1);
        awready = 1'b0;
        idle_cycles($urandom_range(0, 3));
        check_value("axi wvalid before W handshake", 32'd1, 32'(wvalid));
        wready = 1'b1;
        d = wdata;
        s = wstrb;
        idle_cycles(1);
        wready = 1'b0;
        check_value("axi wvalid after W handshake", 32'd0, 32'(wvalid));
        idle_cycles(is_stall_page(a) ? 3 * TIMEOUT_CYCLES : $urandom_range(0, 3));
        if (!is_slverr_page(a) && !is_stall_page(a)) begin
            mem[a[9:2]] = merge_bytes(mem[a[9:2]], d, s);
        end
        bresp = is_slverr_page(a) ? SLVERR : OKAY;
        bvalid = 1'b1;
        while (!bready) begin
            idle_cycles(1);
        end
        idle_cycles(1);
        bvalid = 1'b0;
    endtask

    task automatic serve_read();
        logic [ADDR_W-1:0] a;
        idle_cycles($urandom_range(0, 3));
        arready = 1'b1;
        a = araddr;
        idle_cycles(1);
        arready = 1'b0;
        idle_cycles(is_stall_page(a) ? 3 * TIMEOUT_CYCLES : $urandom_range(0, 3));
        rresp = is_slverr_page(a) ? SLVERR : OKAY;
        if (is_stall_page(a)) begin
            rdata = 32'hBAD0_BAD0;
        end else begin
            rdata = is_slverr_page(a) ? '0 : mem[a[9:2]];
        end
        rvalid = 1'b1;
        while (!rready) begin
            idle_cycles(1);
        end
        idle_cycles(1);
        rvalid = 1'b0;
    endtask

    initial begin : axi_memory
        awready = 1'b0;
        wready = 1'b0;
        bresp = 2'b00;
        bvalid = 1'b0;
        arready = 1'b0;
        rdata = '0;
        rresp = 2'b00;
        rvalid = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        wait (rst_n === 1'b1);
        forever begin
            idle_cycles(1);
            if (awvalid) begin
                serve_write();
            end else if (arvalid) begin
                serve_read();
            end
        end
    end

    initial begin : run_tests
        void'($urandom(47));
        fsb_req = '0;
        grant_ptr = 0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = fill_word(i);
        end
        build_table();
        wait (rst_n === 1'b1);
        idle_cycles(1);
        check_reset_state();
        for (int s = 0; s < steps.size(); s++) begin
            apply_step(s);
        end
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin : watchdog
        longint limit;
        #1;
        limit = longint'(steps.size()) * (4 * TIMEOUT_CYCLES + 20) * 100;
        #(limit);
        $display("watchdog expired before all table steps completed");
        $display("Simulation failed");
        $fatal(1, "run took too long");
    end
endmodule
